//--- flist.f
+incdir+dv
common/ssp_pkg.sv
verilog/ssp_fifo.sv
verilog/ssp_clk_ctrl.sv
tx/ssp_tx_serializer.sv
rx/ssp_rx_deserializer.sv
verilog/ssp_top.sv
dv/ssp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SSP testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --top-module ssp_tb -f flist.f -o ssp_sim \
    && ./obj_dir/ssp_sim > sim.log 2>&1 \
    || echo "build or simulation step returned an error"

grep -qs "^SIMULATION PASSED$" sim.log && echo "run passed" && exit 0
echo "run failed, see sim.log"
exit 1

//--- dv/ssp_tb_tasks.svh
function automatic ssp_pkg::ssp_byte_t random_byte();
    return ssp_pkg::ssp_byte_t'($urandom);
endfunction

task automatic check_byte(input string what, input ssp_pkg::ssp_byte_t got,
                          input ssp_pkg::ssp_byte_t exp);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED at time %0t: %s, got %02h expected %02h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
        errors++;
    end
endtask

// select stays up until bus_idle so writes can run back to back
task automatic bus_write(input ssp_pkg::ssp_byte_t b);
    @(posedge PCLK);
    PSEL   <= 1'b1;
    PWRITE <= 1'b1;
    PWDATA <= b;
endtask

task automatic bus_idle();
    @(posedge PCLK); // previous transfer commits here
    PSEL   <= 1'b0;
    PWRITE <= 1'b0;
endtask

task automatic bus_read(output ssp_pkg::ssp_byte_t got);
    @(posedge PCLK);
    PSEL   <= 1'b1;
    PWRITE <= 1'b0;
    @(negedge PCLK);
    got = PRDATA; // combinational head before the pop edge
endtask

// one write held off while the tx fifo reports full
task automatic write_flow(input ssp_pkg::ssp_byte_t b, input logic keep);
    int waited;
    waited = 0;
    @(negedge PCLK);
    while (SSPTXINTR && waited < 2 * FRAME_CYCLES) begin
        @(negedge PCLK);
        waited++;
    end
    if (SSPTXINTR) begin
        $display("transmit FIFO stayed full at time %0t, write was not sent", $time);
        errors++;
    end else begin
        bus_write(b);
        bus_idle();
        if (keep) begin
            exp_q.push_back(b); // only bytes the rx side can still hold
        end
    end
endtask

task automatic wait_frames(input int target, input int limit);
    int n;
    n = 0;
    while (frames_done < target && n < limit) begin
        @(negedge PCLK);
        n++;
    end
    if (frames_done < target) begin
        $display("timed out at time %0t waiting for frame %0d on SSPTXD", $time, target);
        errors++;
    end
endtask

task automatic wait_rx_data(input int limit);
    int n;
    n = 0;
    @(negedge PCLK);
    while (u_dut.rx_empty && n < limit) begin
        @(negedge PCLK);
        n++;
    end
    if (u_dut.rx_empty) begin
        $display("timed out at time %0t waiting for a received byte", $time);
        errors++;
    end
endtask

task automatic check_frame(input int idx, input ssp_pkg::ssp_byte_t exp);
    check_byte($sformatf("frame %0d bits on SSPTXD", idx), mon_byte[idx], exp);
    check_flag($sformatf("frame %0d sync high %0d cycles, want 2", idx, mon_fss[idx]),
               mon_fss[idx] == 2, 1'b1);
    check_flag($sformatf("frame %0d SSPOE_B low %0d cycles, want %0d", idx, mon_oe[idx],
               FRAME_CYCLES), mon_oe[idx] == FRAME_CYCLES, 1'b1);
endtask

// read one byte against the model head or zero once the model is empty
task automatic read_expect(input string what);
    ssp_pkg::ssp_byte_t got;
    ssp_pkg::ssp_byte_t exp;
    exp = '0;
    if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
    end
    bus_read(got);
    bus_idle();
    check_byte(what, got, exp);
endtask

task automatic report_test(input string name, input int start_errs);
    tests_run++;
    if (errors == start_errs) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, errors - start_errs);
    end
endtask

task automatic test_reset_values();
    int                 start;
    ssp_pkg::ssp_byte_t got;
    start = errors;
    @(negedge PCLK);
    check_flag("SSPOE_B after reset", SSPOE_B, 1'b1);
    check_flag("SSPFSSOUT after reset", SSPFSSOUT, 1'b0);
    check_flag("SSPTXD after reset", SSPTXD, 1'b0);
    check_flag("SSPTXINTR after reset", SSPTXINTR, 1'b0);
    check_flag("SSPRXINTR after reset", SSPRXINTR, 1'b0);
    bus_read(got);
    bus_idle();
    check_byte("read of empty rx FIFO", got, 8'h00);
    report_test("reset values", start);
endtask

task automatic test_single_frame();
    int                 start;
    int                 base;
    ssp_pkg::ssp_byte_t b;
    start = errors;
    base  = frames_done;
    b     = random_byte();
    write_flow(b, 1'b1);
    wait_frames(base + 1, FRAME_CYCLES + START_MAX + 2);
    check_frame(base, b);
    check_flag("no SSPOE_B low outside frames", stray_oe == 0, 1'b1);
    check_flag("SSPCLKOUT rising with each launch", clk_slip == 0, 1'b1);
    wait_rx_data(RX_LAT_MAX);
    read_expect("single frame readback");
    report_test("single frame", start);
endtask

task automatic test_back_to_back();
    int                 start;
    int                 base;
    ssp_pkg::ssp_byte_t bytes [4];
    start = errors;
    base  = frames_done;
    for (int i = 0; i < 4; i++) begin
        bytes[i] = random_byte();
        bus_write(bytes[i]); // one write per cycle
        exp_q.push_back(bytes[i]);
    end
    bus_idle();
    wait_frames(base + 4, 4 * FRAME_CYCLES + START_MAX + 2);
    for (int i = 0; i < 4; i++) begin
        check_frame(base + i, bytes[i]);
        if (i > 0) begin
            check_flag($sformatf("idle gap before frame %0d is %0d", base + i,
                       mon_gap[base + i]), mon_gap[base + i] == 0, 1'b1);
        end
    end
    check_flag("no SSPOE_B low outside frames", stray_oe == 0, 1'b1);
    check_flag("SSPCLKOUT rising with each launch", clk_slip == 0, 1'b1);
    for (int i = 0; i < 4; i++) begin
        wait_rx_data(RX_LAT_MAX);
        read_expect($sformatf("back to back readback %0d", i));
    end
    report_test("back to back frames", start);
endtask

// writes take priority and reads drain the rx side while a write waits
task automatic test_flow_control();
    int                 start;
    int                 n_wr;
    int                 n_rd;
    int                 guard;
    logic               seen_full;
    logic               can_write;
    logic               has_data;
    ssp_pkg::ssp_byte_t b;
    start     = errors;
    n_wr      = 0;
    n_rd      = 0;
    guard     = 0;
    seen_full = 1'b0;
    while (n_rd < 8 && guard < 8 * FRAME_CYCLES + 100) begin
        @(negedge PCLK);
        guard++;
        if (SSPTXINTR) begin
            seen_full = 1'b1;
        end
        can_write = (n_wr < 8) && !SSPTXINTR;
        has_data  = !u_dut.rx_empty;
        if (can_write) begin
            b = random_byte();
            bus_write(b);
            bus_idle();
            exp_q.push_back(b);
            n_wr++;
        end else if (has_data) begin
            read_expect($sformatf("flow control readback %0d", n_rd));
            n_rd++;
        end
    end
    if (n_rd < 8) begin
        $display("flow control test stalled after %0d writes and %0d reads", n_wr, n_rd);
        errors++;
    end
    check_flag("SSPTXINTR seen high", seen_full, 1'b1);
    report_test("transmit flow control", start);
endtask

task automatic test_rx_overflow();
    int start;
    int base;
    start = errors;
    base  = frames_done;
    for (int i = 0; i < 6; i++) begin
        write_flow(random_byte(), i < DEPTH); // bytes past rx depth are dropped
    end
    wait_frames(base + 6, 6 * FRAME_CYCLES + START_MAX + 2);
    repeat (RX_LAT_MAX) @(negedge PCLK); // let the last byte land or drop
    check_flag("SSPRXINTR with rx FIFO full", SSPRXINTR, 1'b1);
    for (int i = 0; i < 5; i++) begin
        read_expect($sformatf("overflow readback %0d", i));
    end
    @(negedge PCLK);
    check_flag("SSPRXINTR after draining", SSPRXINTR, 1'b0);
    report_test("receive overflow", start);
endtask

//--- dv/ssp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ssp_tb;

    localparam int DEPTH        = ssp_pkg::SSP_FIFO_DEPTH;
    localparam int FRAME_CYCLES = 2 * (ssp_pkg::BYTE_BITS + 1); // sync plus 8 bits of 2 PCLK each
    localparam int START_MAX    = 4;  // write into idle tx until sync rises
    localparam int RX_LAT_MAX   = 8;  // last bit until byte readable
    localparam int TOTAL_FRAMES = 1 + 4 + 8 + 6;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * FRAME_CYCLES + 200;
    localparam int MON_SLOTS    = 64;

    logic               PCLK;
    logic               rst_n;
    logic               PSEL;
    logic               PWRITE;
    ssp_pkg::ssp_byte_t PWDATA;
    ssp_pkg::ssp_byte_t PRDATA;
    logic               SSPOE_B;
    logic               SSPTXD;
    logic               SSPCLKOUT;
    logic               SSPFSSOUT;
    logic               SSPTXINTR;
    logic               SSPRXINTR;

    // bookkeeping
    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycles       = 0;

    ssp_pkg::ssp_byte_t exp_q [$]; // bytes the host should read back in order

    // frame monitor state with one slot per finished frame
    logic               in_frame;
    int                 pos;
    int                 gap;       // idle cycles since the last frame
    int                 start_gap; // gap seen when this frame began
    int                 oe_cnt;
    int                 fss_cnt;
    int                 stray_oe;  // oe low outside any frame
    int                 clk_slip;  // serial clock out of phase inside a frame
    int                 frames_done;
    ssp_pkg::ssp_byte_t cap;
    ssp_pkg::ssp_byte_t mon_byte [MON_SLOTS];
    int                 mon_oe   [MON_SLOTS];
    int                 mon_fss  [MON_SLOTS];
    int                 mon_gap  [MON_SLOTS];

    `include "ssp_tb_tasks.svh"

    initial PCLK = 1'b0;
    always #2 PCLK = ~PCLK; // 4 ns period

    // tx lines loop straight back into rx lines
    ssp_top #(.DEPTH(DEPTH)) u_dut (
        .PCLK      (PCLK),
        .rst_n     (rst_n),
        .PSEL      (PSEL),
        .PWRITE    (PWRITE),
        .PWDATA    (PWDATA),
        .SSPCLKIN  (SSPCLKOUT),
        .SSPFSSIN  (SSPFSSOUT),
        .SSPRXD    (SSPTXD),
        .PRDATA    (PRDATA),
        .SSPOE_B   (SSPOE_B),
        .SSPTXD    (SSPTXD),
        .SSPCLKOUT (SSPCLKOUT),
        .SSPFSSOUT (SSPFSSOUT),
        .SSPTXINTR (SSPTXINTR),
        .SSPRXINTR (SSPRXINTR)
    );

    // frame monitor samples mid-cycle where outputs have settled
    always @(negedge PCLK) begin : frame_mon
        int p; // position in the 18 cycle window
        p = in_frame ? pos : 0;
        if (!rst_n) begin
            in_frame    <= 1'b0;
            pos         <= 0;
            gap         <= 0;
            stray_oe    <= 0;
            clk_slip    <= 0;
            frames_done <= 0;
        end else if (!in_frame && !SSPFSSOUT) begin
            gap <= gap + 1;
            if (!SSPOE_B) begin
                stray_oe <= stray_oe + 1; // oe must be released between frames
            end
        end else begin
            oe_cnt  <= ((p == 0) ? 0 : oe_cnt) + (SSPOE_B ? 0 : 1);
            fss_cnt <= ((p == 0) ? 0 : fss_cnt) + (SSPFSSOUT ? 1 : 0);
            if (SSPCLKOUT !== ((p % 2) == 0)) begin
                clk_slip <= clk_slip + 1; // serial clock rises with every launch
            end
            if (p == 0) begin
                start_gap <= gap;
            end
            if (p >= 3 && (p % 2) == 1) begin
                cap <= {cap[6:0], SSPTXD}; // second half of each bit with msb first
            end
            if (p == FRAME_CYCLES - 1) begin
                mon_byte[frames_done] <= {cap[6:0], SSPTXD};
                mon_oe[frames_done]   <= oe_cnt + (SSPOE_B ? 0 : 1);
                mon_fss[frames_done]  <= fss_cnt + (SSPFSSOUT ? 1 : 0);
                mon_gap[frames_done]  <= start_gap;
                frames_done           <= frames_done + 1;
                in_frame              <= 1'b0;
                gap                   <= 0;
            end else begin
                in_frame <= 1'b1;
                pos      <= p + 1;
            end
        end
    end

    // run limit from the frame count
    always @(posedge PCLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, tests did not finish", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(61)); // one seed for the whole run
        PSEL   <= 1'b0;
        PWRITE <= 1'b0;
        PWDATA <= '0;
        rst_n  <= 1'b0;
        repeat (2) @(posedge PCLK);
        rst_n <= 1'b1;
        @(posedge PCLK);

        test_reset_values();
        test_single_frame();
        test_back_to_back();
        test_flow_control();
        test_rx_overflow();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ssp_top.sv
`timescale 1ns/1ps
`default_nettype none

module ssp_top #(
    parameter int DEPTH = ssp_pkg::SSP_FIFO_DEPTH
) (
    input  wire                PCLK,
    input  wire                rst_n,
    input  wire                PSEL,
    input  wire                PWRITE,
    input  ssp_pkg::ssp_byte_t PWDATA,
    input  wire                SSPCLKIN,
    input  wire                SSPFSSIN,
    input  wire                SSPRXD,
    output ssp_pkg::ssp_byte_t PRDATA,
    output logic               SSPOE_B,
    output logic               SSPTXD,
    output logic               SSPCLKOUT,
    output logic               SSPFSSOUT,
    output logic               SSPTXINTR,
    output logic               SSPRXINTR
);

    logic tx_push, tx_pop, tx_full, tx_empty;
    logic rx_push, rx_pop, rx_full, rx_empty;
    logic tx_tick, rx_tick, rx_fss, rx_data;

    ssp_pkg::ssp_byte_t tx_head;
    ssp_pkg::ssp_byte_t rx_head;
    ssp_pkg::ssp_byte_t rx_byte;

    // bus decode, one transfer per selected cycle
    assign tx_push = PSEL && PWRITE;
    assign rx_pop  = PSEL && !PWRITE;

    assign PRDATA = rx_empty ? '0 : rx_head; // zero when nothing to read

    assign SSPTXINTR = tx_full;
    assign SSPRXINTR = rx_full;

    ssp_clk_ctrl u_clk_ctrl (
        .PCLK      (PCLK),
        .rst_n     (rst_n),
        .SSPCLKIN  (SSPCLKIN),
        .SSPFSSIN  (SSPFSSIN),
        .SSPRXD    (SSPRXD),
        .SSPCLKOUT (SSPCLKOUT),
        .tx_tick   (tx_tick),
        .rx_tick   (rx_tick),
        .rx_fss    (rx_fss),
        .rx_data   (rx_data)
    );

    // host to serializer
    ssp_fifo #(.DEPTH(DEPTH)) u_tx_fifo (
        .PCLK  (PCLK),
        .rst_n (rst_n),
        .push  (tx_push),
        .wdata (PWDATA),
        .pop   (tx_pop),
        .rdata (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    // deserializer to host
    ssp_fifo #(.DEPTH(DEPTH)) u_rx_fifo (
        .PCLK  (PCLK),
        .rst_n (rst_n),
        .push  (rx_push),
        .wdata (rx_byte),
        .pop   (rx_pop),
        .rdata (rx_head),
        .full  (rx_full),
        .empty (rx_empty)
    );

    ssp_tx_serializer u_tx (
        .PCLK      (PCLK),
        .rst_n     (rst_n),
        .tx_tick   (tx_tick),
        .tx_empty  (tx_empty),
        .tx_head   (tx_head),
        .tx_pop    (tx_pop),
        .SSPTXD    (SSPTXD),
        .SSPFSSOUT (SSPFSSOUT),
        .SSPOE_B   (SSPOE_B)
    );

    ssp_rx_deserializer u_rx (
        .PCLK    (PCLK),
        .rst_n   (rst_n),
        .rx_tick (rx_tick),
        .rx_fss  (rx_fss),
        .rx_data (rx_data),
        .rx_push (rx_push),
        .rx_byte (rx_byte)
    );

endmodule

`default_nettype wire

//--- rx/ssp_rx_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module ssp_rx_deserializer (
    input  wire                PCLK,
    input  wire                rst_n,
    input  wire                rx_tick,
    input  wire                rx_fss,
    input  wire                rx_data,
    output logic               rx_push,
    output ssp_pkg::ssp_byte_t rx_byte
);

    ssp_pkg::rx_state_e            state;
    logic [ssp_pkg::BIT_CNT_W-1:0] bit_cnt; // samples still expected
    ssp_pkg::ssp_byte_t            shift_q; // assembled msb first

    logic sample; // data bit sample this cycle
    logic last;   // final bit of the byte

    assign sample = rx_tick && (state == ssp_pkg::RX_SHIFT);
    assign last   = sample && (bit_cnt == ssp_pkg::BIT_CNT_W'(1));

    // byte assembly, payload only
    always_ff @(posedge PCLK) begin
        if (sample) begin
            shift_q <= {shift_q[6:0], rx_data}; // earlier bits move up
        end
    end

    assign rx_byte = shift_q; // complete when rx_push is high

    always_ff @(posedge PCLK) begin
        if (!rst_n) begin
            state   <= ssp_pkg::RX_IDLE;
            bit_cnt <= '0;
            rx_push <= 1'b0;
        end else begin
            rx_push <= last; // one cycle after the last shift

            case (state)
                ssp_pkg::RX_IDLE: begin
                    if (rx_tick && rx_fss) begin
                        // sync seen, data follows on next samples
                        state   <= ssp_pkg::RX_SHIFT;
                        bit_cnt <= ssp_pkg::BIT_CNT_W'(ssp_pkg::BYTE_BITS);
                    end
                end
                ssp_pkg::RX_SHIFT: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                    if (last) begin
                        state <= ssp_pkg::RX_IDLE; // ready for a chained sync
                    end
                end
                default: begin
                    state <= ssp_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tx/ssp_tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module ssp_tx_serializer (
    input  wire                PCLK,
    input  wire                rst_n,
    input  wire                tx_tick,
    input  wire                tx_empty,
    input  ssp_pkg::ssp_byte_t tx_head,
    output logic               tx_pop,
    output logic               SSPTXD,
    output logic               SSPFSSOUT,
    output logic               SSPOE_B
);

    ssp_pkg::tx_state_e              state;
    ssp_pkg::ssp_byte_t              shift_q;  // outgoing byte, msb at top
    logic [ssp_pkg::BIT_CNT_W-1:0]   bit_cnt;  // bits still to launch

    logic frame_done; // last data bit has had its full period
    logic load;       // take a new byte from the fifo this tick

    assign frame_done = (state == ssp_pkg::TX_SHIFT) && (bit_cnt == '0);

    // start from idle or chain straight into the next frame
    assign load = tx_tick && !tx_empty &&
                  ((state == ssp_pkg::TX_IDLE) || frame_done);

    assign tx_pop = load; // fifo advances on the same edge

    // shift register holds payload only
    always_ff @(posedge PCLK) begin
        if (load) begin
            shift_q <= tx_head;
        end else if (tx_tick && (state != ssp_pkg::TX_IDLE) && (bit_cnt != '0)) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge PCLK) begin
        if (!rst_n) begin
            state     <= ssp_pkg::TX_IDLE;
            bit_cnt   <= '0;
            SSPTXD    <= 1'b0;
            SSPFSSOUT <= 1'b0;
            SSPOE_B   <= 1'b1;
        end else if (load) begin
            // sync period, data line held low
            state     <= ssp_pkg::TX_SYNC;
            bit_cnt   <= ssp_pkg::BIT_CNT_W'(ssp_pkg::BYTE_BITS);
            SSPTXD    <= 1'b0;
            SSPFSSOUT <= 1'b1;
            SSPOE_B   <= 1'b0;
        end else if (tx_tick) begin
            case (state)
                ssp_pkg::TX_SYNC: begin
                    state     <= ssp_pkg::TX_SHIFT;
                    SSPFSSOUT <= 1'b0;
                    SSPTXD    <= shift_q[7]; // msb first
                    bit_cnt   <= bit_cnt - 1'b1;
                end
                ssp_pkg::TX_SHIFT: begin
                    if (frame_done) begin
                        // nothing queued, release the line
                        state   <= ssp_pkg::TX_IDLE;
                        SSPTXD  <= 1'b0;
                        SSPOE_B <= 1'b1;
                    end else begin
                        SSPTXD  <= shift_q[7];
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= ssp_pkg::TX_IDLE; // idle with empty fifo, or stray encoding
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/ssp_clk_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ssp_clk_ctrl (
    input  wire  PCLK,
    input  wire  rst_n,
    input  wire  SSPCLKIN,
    input  wire  SSPFSSIN,
    input  wire  SSPRXD,
    output logic SSPCLKOUT,
    output logic tx_tick,
    output logic rx_tick,
    output logic rx_fss,
    output logic rx_data
);

    logic sclk; // PCLK/2 toggle

    // two-flop synchronisers, all three lines get the same depth
    logic [1:0] clk_sync;
    logic [1:0] fss_sync;
    logic [1:0] rxd_sync;
    logic       clk_prev; // last synced serial clock, for edge detect

    always_ff @(posedge PCLK) begin
        if (!rst_n) begin
            sclk <= 1'b0; // serial clock starts low
        end else begin
            sclk <= ~sclk;
        end
    end

    assign SSPCLKOUT = sclk;
    assign tx_tick   = ~sclk; // next edge raises SSPCLKOUT

    always_ff @(posedge PCLK) begin
        if (!rst_n) begin
            clk_sync <= '0;
            fss_sync <= '0;
            rxd_sync <= '0;
            clk_prev <= 1'b0;
        end else begin
            clk_sync <= {clk_sync[0], SSPCLKIN};
            fss_sync <= {fss_sync[0], SSPFSSIN};
            rxd_sync <= {rxd_sync[0], SSPRXD};
            clk_prev <= clk_sync[1];
        end
    end

    // falling edge of serial clock is mid-bit
    assign rx_tick = clk_prev && !clk_sync[1];

    // same stage as the clock, so they line up with rx_tick
    assign rx_fss  = fss_sync[1];
    assign rx_data = rxd_sync[1];

endmodule

`default_nettype wire

//--- verilog/ssp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ssp_fifo #(
    parameter int DEPTH = ssp_pkg::SSP_FIFO_DEPTH
) (
    input  wire               PCLK,
    input  wire               rst_n,
    input  wire               push,
    input  ssp_pkg::ssp_byte_t wdata,
    input  wire               pop,
    output ssp_pkg::ssp_byte_t rdata,
    output logic              full,
    output logic              empty
);

    localparam int AW = $clog2(DEPTH); // index bits without the wrap bit

    ssp_pkg::ssp_byte_t mem [DEPTH]; // byte storage

    logic [AW:0] wptr; // msb is the wrap bit
    logic [AW:0] rptr;

    logic do_push;
    logic do_pop;

    // pointer compare on registered values only
    assign empty = (wptr == rptr);
    assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

    assign do_push = push && !full;  // push into full is dropped
    assign do_pop  = pop && !empty;  // pop from empty is a no-op

    // head of queue is always visible
    assign rdata = mem[rptr[AW-1:0]];

    // storage write
    always_ff @(posedge PCLK) begin
        if (do_push) begin
            mem[wptr[AW-1:0]] <= wdata;
        end
    end

    // write pointer
    always_ff @(posedge PCLK) begin
        if (!rst_n) begin
            wptr <= '0;
        end else if (do_push) begin
            wptr <= wptr + 1'b1; // wraps naturally into the extra bit
        end
    end

    // read pointer
    always_ff @(posedge PCLK) begin
        if (!rst_n) begin
            rptr <= '0;
        end else if (do_pop) begin
            rptr <= rptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- common/ssp_pkg.sv
`default_nettype none

package ssp_pkg;

    // one serial payload byte
    typedef logic [7:0] ssp_byte_t;

    // data bits per frame, msb first on the wire
    localparam int BYTE_BITS = 8;

    // bit counter wide enough to hold BYTE_BITS itself
    localparam int BIT_CNT_W = $clog2(BYTE_BITS + 1);

    // default fifo depth, must be a power of two
    localparam int SSP_FIFO_DEPTH = 4;

    // transmit frame states
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0, // line quiet, oe released
        TX_SYNC  = 2'd1, // one serial period of frame sync
        TX_SHIFT = 2'd2  // data bits going out
    } tx_state_e;

    // receive frame states
    typedef enum logic {
        RX_IDLE  = 1'b0, // waiting for frame sync
        RX_SHIFT = 1'b1  // collecting data bits
    } rx_state_e;

endpackage

`default_nettype wire
